// ==== src.f ====
+incdir+common
common/core_ctrl_pkg.sv
common/rename_pkg.sv
rename/busy_table.sv
rename/free_list.sv
rename/rename_map.sv
src/dispatch_ctrl.sv
src/rename_top.sv
dv/rename_props.sv
dv/rename_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the rename stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module rename_tb -o rename_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/rename_sim > sim.log 2>&1
cat sim.log

grep -q "Something failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Everything OK" sim.log || { echo "Simulation ended without passing"; exit 1; }
echo "Simulation passed"

// ==== dv/rename_tb.sv ====
`include "rename_defines.svh"

module rename_tb import rename_pkg::*, core_ctrl_pkg::*; ();

    localparam int STALL_CYC = 6;   // Cycles ack must stay low on a stall
    localparam int STEP_CYC  = 40;  // Watchdog budget per step

    typedef struct {
        string      name;
        rn_group_t  grp;
        preg_port_t wb_int, wb_mem, rel0, rel1;
        logic       flush;
        logic       late;       // Pulses inside the handshake, not before it
        logic       exp_stall;  // Group has to wait for a release
    } step_t;

    logic       clk = 1'b0;
    logic       rst, flush, disp_req, disp_ack;
    rn_group_t  disp_group;
    rn_result_t disp_result;
    preg_port_t wb_int, wb_mem, rel0, rel1;

    step_t steps [$];
    int    seed = 452;
    int    errors = 0;
    int    checks = 0;
    logic  table_ready = 1'b0;

    // Reference state
    preg_t map_m  [`ARCH_REGS];
    logic  busy_m [`PHYS_REGS];
    preg_t free_m [$];       // Head at index 0
    logic  has_m  [2];
    preg_t pd_m   [2];

    always #2 clk = ~clk;

    rename_top uut (
        .clk, .rst, .flush, .disp_req, .disp_group, .disp_ack, .disp_result,
        .wb_int, .wb_mem, .rel0, .rel1
    );

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", what, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////

    function automatic rn_instr_t make_instr(input logic v, input op_kind_e op,
                                             input int s1, input int s2, input int d);
        rn_instr_t ins;
        ins.valid = v;
        ins.op    = op;
        ins.src1  = areg_t'(s1);
        ins.src2  = areg_t'(s2);
        ins.dst   = areg_t'(d);
        return ins;
    endfunction

    function automatic preg_port_t make_port(input logic en, input int tag);
        preg_port_t p;
        p.en  = en;
        p.tag = preg_t'(tag);
        return p;
    endfunction

    function automatic int random_areg();
        return $random(seed) & 31;
    endfunction

    task automatic add_step(input string name, input rn_instr_t i0, input rn_instr_t i1,
                            input int wbi, input int wbm, input int r0, input int r1,
                            input logic fl, input logic late, input logic stall);
        step_t s;
        s.name      = name;
        s.grp[0]    = i0;
        s.grp[1]    = i1;
        s.wb_int    = make_port(wbi >= 0, wbi);   // Negative tag means idle port
        s.wb_mem    = make_port(wbm >= 0, wbm);
        s.rel0      = make_port(r0 >= 0, r0);
        s.rel1      = make_port(r1 >= 0, r1);
        s.flush     = fl;
        s.late      = late;
        s.exp_stall = stall;
        steps.push_back(s);
    endtask

    task automatic build_table();
        rn_instr_t none;
        none = make_instr(1'b0, OP_ALU, 0, 0, 0);
        add_step("reset_alu_pair", make_instr(1, OP_ALU, 1, 2, 3),
                 make_instr(1, OP_ALU, 4, 5, 6), -1, -1, -1, -1, 0, 0, 0);
        add_step("dep_waw", make_instr(1, OP_ALU, 7, 8, 9),
                 make_instr(1, OP_ALU, 9, 9, 9), -1, -1, -1, -1, 0, 0, 0);
        add_step("store_branch", make_instr(1, OP_STORE, 3, 9, 0),
                 make_instr(1, OP_BRANCH, 1, 6, 0), -1, -1, -1, -1, 0, 0, 0);
        add_step("alu_after_store", make_instr(1, OP_ALU, 3, 10, 11), none,
                 -1, -1, -1, -1, 0, 0, 0);
        add_step("wb_clear", make_instr(1, OP_ALU, 3, 9, 12),
                 make_instr(1, OP_LOAD, 6, 1, 13), 32, 35, -1, -1, 0, 0, 0);
        // Writeback of the tag being allocated in the same cycle
        // Slot 1 store reads that tag through the set bypass
        add_step("wb_with_set", make_instr(1, OP_ALU, 3, 4, 14),
                 make_instr(1, OP_STORE, 14, 4, 0),
                 39, -1, -1, -1, 0, 1, 0);
        add_step("read_after_wb_set", make_instr(1, OP_ALU, 14, 14, 15),
                 make_instr(1, OP_ALU, random_areg(), random_areg(), random_areg()),
                 -1, -1, -1, -1, 0, 0, 0);
        // Drain the remaining 22 free registers
        for (int k = 0; k < 11; k++) begin
            add_step($sformatf("fill_%0d", k),
                     make_instr(1, OP_ALU, random_areg(), random_areg(), k),
                     make_instr(1, OP_LOAD, random_areg(), random_areg(), k + 16),
                     -1, -1, -1, -1, 0, 0, 0);
        end
        add_step("stall_release", make_instr(1, OP_ALU, 20, 21, 22),
                 make_instr(1, OP_ALU, 22, 3, 23), -1, -1, 3, 6, 0, 1, 1);
        // Arch 6 maps back to tag 6, busy until the flush
        add_step("flush_restore", make_instr(1, OP_ALU, 6, 2, 3),
                 make_instr(1, OP_ALU, 3, 4, 5), -1, -1, -1, -1, 1, 0, 0);
        add_step("after_flush_load_store",
                 make_instr(1, OP_LOAD, random_areg(), random_areg(), 7),
                 make_instr(1, OP_STORE, random_areg(), random_areg(), 0),
                 -1, -1, -1, -1, 0, 0, 0);
        add_step("branch_then_alu",
                 make_instr(1, OP_BRANCH, random_areg(), random_areg(), 0),
                 make_instr(1, OP_ALU, random_areg(), random_areg(), 8),
                 -1, -1, -1, -1, 0, 0, 0);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////

    task automatic model_reset();
        free_m.delete();
        for (int i = 0; i < `ARCH_REGS; i++) begin
            map_m[i] = preg_t'(i);  // Identity
        end
        for (int i = 0; i < `PHYS_REGS; i++) begin
            busy_m[i] = 1'b0;
        end
        for (int i = `ARCH_REGS; i < `PHYS_REGS; i++) begin
            free_m.push_back(preg_t'(i));
        end
    endtask

    task automatic model_pulses(input step_t s);
        if (s.flush) begin
            model_reset();
        end else begin
            if (s.wb_int.en) busy_m[s.wb_int.tag] = 1'b0;
            if (s.wb_mem.en) busy_m[s.wb_mem.tag] = 1'b0;
            if (s.rel0.en) free_m.push_back(s.rel0.tag);
            if (s.rel1.en) free_m.push_back(s.rel1.tag);  // Lands behind rel0
        end
    endtask

    function automatic logic writes_dst(input rn_instr_t ins);
        return ins.valid && (ins.op == OP_ALU || ins.op == OP_LOAD);
    endfunction

    // New destinations read busy, then same-cycle writebacks, then stored bit
    function automatic logic read_busy(input preg_t t, input step_t s, input logic conc);
        if ((has_m[0] && t == pd_m[0]) || (has_m[1] && t == pd_m[1])) return 1'b1;
        if (conc && s.wb_int.en && s.wb_int.tag == t) return 1'b0;
        if (conc && s.wb_mem.en && s.wb_mem.tag == t) return 1'b0;
        return busy_m[t];
    endfunction

    task automatic model_rename(input step_t s, input logic conc, output rn_result_t want);
        rn_out_t o0, o1;
        rn_instr_t a, b;
        a = s.grp[0];
        b = s.grp[1];
        has_m[0] = writes_dst(a);
        has_m[1] = writes_dst(b);
        pd_m[0] = '0;
        pd_m[1] = '0;
        if (has_m[0]) pd_m[0] = free_m.pop_front();  // Oldest writer first
        if (has_m[1]) pd_m[1] = free_m.pop_front();
        o0 = '0;
        o1 = '0;
        if (a.valid) begin
            o0.valid     = 1'b1;
            o0.psrc1     = map_m[a.src1];
            o0.psrc2     = map_m[a.src2];
            o0.src1_busy = read_busy(o0.psrc1, s, conc);
            o0.src2_busy = read_busy(o0.psrc2, s, conc);
            o0.has_dst   = has_m[0];
            o0.pdst      = pd_m[0];
            o0.old_pdst  = has_m[0] ? map_m[a.dst] : '0;
        end
        if (b.valid) begin
            o1.valid     = 1'b1;
            o1.psrc1     = (has_m[0] && b.src1 == a.dst) ? pd_m[0] : map_m[b.src1];
            o1.psrc2     = (has_m[0] && b.src2 == a.dst) ? pd_m[0] : map_m[b.src2];
            o1.src1_busy = read_busy(o1.psrc1, s, conc);
            o1.src2_busy = read_busy(o1.psrc2, s, conc);
            o1.has_dst   = has_m[1];
            o1.pdst      = pd_m[1];
            if (has_m[1]) o1.old_pdst = (has_m[0] && b.dst == a.dst) ? pd_m[0] : map_m[b.dst];
        end
        want[0] = o0;
        want[1] = o1;
        if (conc) model_pulses(s);  // Clears before sets, pushes after pops
        if (has_m[0]) begin
            map_m[a.dst]    = pd_m[0];
            busy_m[pd_m[0]] = 1'b1;
        end
        if (has_m[1]) begin
            map_m[b.dst]    = pd_m[1];
            busy_m[pd_m[1]] = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Driving the DUT
    ////////////////////////////////////////////////////////////////////

    task automatic drive_pulses(input step_t s);
        wb_int = s.wb_int;
        wb_mem = s.wb_mem;
        rel0   = s.rel0;
        rel1   = s.rel1;
        flush  = s.flush;
        @(negedge clk);
        wb_int = '0;    // One-cycle pulses
        wb_mem = '0;
        rel0   = '0;
        rel1   = '0;
        flush  = 1'b0;
    endtask

    task automatic run_step(input step_t s);
        rn_result_t want;
        logic       stall_m;
        int         need;
        if (!s.late) begin
            drive_pulses(s);
            model_pulses(s);
        end
        need    = int'(writes_dst(s.grp[0])) + int'(writes_dst(s.grp[1]));
        stall_m = need > free_m.size();
        check_value({s.name, " stall"}, 64'(s.exp_stall), 64'(stall_m));
        if (s.late && stall_m) model_pulses(s);  // Releases arrive during the stall
        model_rename(s, s.late && !stall_m, want);
        disp_group = s.grp;
        disp_req   = 1'b1;
        @(negedge clk);  // Req sampled, rename cycle
        if (s.exp_stall) begin
            repeat (STALL_CYC) begin
                check_value({s.name, " ack during stall"}, 64'd0, 64'(disp_ack));
                @(negedge clk);
            end
        end
        if (s.late) drive_pulses(s);
        while (!disp_ack) @(negedge clk);
        check_value({s.name, " slot0"}, 64'(want[0]), 64'(disp_result[0]));
        check_value({s.name, " slot1"}, 64'(want[1]), 64'(disp_result[1]));
        disp_req = 1'b0;
        @(negedge clk);
        while (disp_ack) @(negedge clk);
        @(negedge clk);  // Controller back in idle
    endtask

    initial begin
        rst        = 1'b1;
        flush      = 1'b0;
        disp_req   = 1'b0;
        disp_group = '0;
        wb_int     = '0;
        wb_mem     = '0;
        rel0       = '0;
        rel1       = '0;
        build_table();
        table_ready = 1'b1;
        model_reset();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("reset ack", 64'd0, 64'(disp_ack));
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (table_ready);
        repeat (steps.size() * STEP_CYC) @(posedge clk);
        $display("Timeout: dispatch handshake did not finish within %0d cycles",
                 steps.size() * STEP_CYC);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== dv/rename_props.sv ====
`include "rename_defines.svh"

module rename_props import rename_pkg::*; (
    input logic               clk,
    input logic               rst,
    input logic               flush,
    input logic               req,
    input logic               ack,
    input logic               fl_pop0,
    input logic               fl_pop1,
    input preg_t              fl_head0,
    input preg_t              fl_head1,
    input logic [`PREG_W-1:0] fl_cnt
);

    // Ack only drops once the source let go of req, or on a flush
    ack_falls_after_req: assert property (@(posedge clk) disable iff (rst)
        $fell(ack) |-> (!$past(req) || $past(flush)))
        else $error("ack fell while req was still high");

    ack_low_after_reset: assert property (@(posedge clk) $past(rst) |-> !ack)
        else $error("ack high right after reset");

    // Double allocation must hand out two distinct tags
    pops_distinct: assert property (@(posedge clk) disable iff (rst)
        (fl_pop0 && fl_pop1) |-> (fl_head0 != fl_head1))
        else $error("two pops returned the same tag");

    free_cnt_bound: assert property (@(posedge clk) disable iff (rst)
        fl_cnt <= `PREG_W'(`PHYS_REGS - `ARCH_REGS))
        else $error("free count above 32");

endmodule

bind dispatch_ctrl rename_props u_props (
    .clk (clk), .rst (rst), .flush (flush), .req (req), .ack (ack),
    .fl_pop0 (fl_pop0), .fl_pop1 (fl_pop1),
    .fl_head0 (fl_head0), .fl_head1 (fl_head1), .fl_cnt (fl_cnt)
);

// ==== src/rename_top.sv ====
`include "rename_defines.svh"

module rename_top import rename_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,        // Rollback to reset contents
    // Dispatch
    input  logic       disp_req,
    input  rn_group_t  disp_group,
    output logic       disp_ack,
    output rn_result_t disp_result,
    // Writeback
    input  preg_port_t wb_int,
    input  preg_port_t wb_mem,
    // Commit release
    input  preg_port_t rel0,
    input  preg_port_t rel1
);

    // Map
    areg_t   map_rd_areg [2*`GROUP_N];
    preg_t   map_rd_preg [2*`GROUP_N];
    map_wr_t map_wr0, map_wr1;
    preg_t   map_old0, map_old1;
    // Free list
    logic               fl_pop0, fl_pop1;
    preg_t              fl_head0, fl_head1;
    logic [`PREG_W-1:0] fl_cnt;
    // Busy table
    preg_port_t bt_set0, bt_set1;
    preg_t      bt_rd_tag  [2*`GROUP_N];
    logic       bt_rd_busy [2*`GROUP_N];

    ////////////////////////////////////////////////////////////////////
    // Instances
    ////////////////////////////////////////////////////////////////////

    dispatch_ctrl u_ctrl (
        .clk, .rst, .flush,
        .req (disp_req), .group (disp_group), .ack (disp_ack), .result (disp_result),
        .map_rd_areg, .map_rd_preg, .map_wr0, .map_wr1, .map_old0, .map_old1,
        .fl_pop0, .fl_pop1, .fl_head0, .fl_head1, .fl_cnt,
        .bt_set0, .bt_set1, .bt_rd_tag, .bt_rd_busy
    );

    rename_map u_map (
        .clk, .rst, .flush,
        .rd_areg (map_rd_areg), .rd_preg (map_rd_preg),
        .wr0 (map_wr0), .wr1 (map_wr1), .old0 (map_old0), .old1 (map_old1)
    );

    free_list u_fl (
        .clk, .rst, .flush,
        .pop0 (fl_pop0), .pop1 (fl_pop1), .head0 (fl_head0), .head1 (fl_head1),
        .free_cnt (fl_cnt),
        .push0 (rel0), .push1 (rel1)  // Old tags back at commit
    );

    busy_table u_bt (
        .clk, .rst, .flush,
        .set0 (bt_set0), .set1 (bt_set1),
        .clr0 (wb_int), .clr1 (wb_mem),  // Writeback clears
        .rd_tag (bt_rd_tag), .rd_busy (bt_rd_busy)
    );

endmodule

// ==== src/dispatch_ctrl.sv ====
`include "rename_defines.svh"

module dispatch_ctrl import rename_pkg::*, core_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    // Four-phase dispatch handshake
    input  logic               req,
    input  rn_group_t          group,
    output logic               ack,
    output rn_result_t         result,
    // Rename map
    output areg_t              map_rd_areg [2*`GROUP_N],
    input  preg_t              map_rd_preg [2*`GROUP_N],
    output map_wr_t            map_wr0,
    output map_wr_t            map_wr1,
    input  preg_t              map_old0,
    input  preg_t              map_old1,
    // Free list
    output logic               fl_pop0,
    output logic               fl_pop1,
    input  preg_t              fl_head0,
    input  preg_t              fl_head1,
    input  logic [`PREG_W-1:0] fl_cnt,
    // Busy table
    output preg_port_t         bt_set0,
    output preg_port_t         bt_set1,
    output preg_t              bt_rd_tag  [2*`GROUP_N],
    input  logic               bt_rd_busy [2*`GROUP_N]
);

    disp_state_e state_q, state_d;
    rn_result_t  result_q, res_d;

    logic [1:0] has_dst;  // Per slot
    logic [1:0] need;     // Registers to pop
    logic       go;       // Rename fires this edge
    preg_t      pdst0, pdst1;
    logic       dep1, dep2, waw;

    ////////////////////////////////////////////////////////////////////
    // Allocation and intra-group forwarding
    ////////////////////////////////////////////////////////////////////

    assign has_dst[0] = group[0].valid && (group[0].op inside {OP_ALU, OP_LOAD});
    assign has_dst[1] = group[1].valid && (group[1].op inside {OP_ALU, OP_LOAD});
    assign need       = {1'b0, has_dst[0]} + {1'b0, has_dst[1]};
    assign go         = (state_q == DS_RENAME) && !flush && (fl_cnt >= {4'b0, need});

    assign pdst0 = fl_head0;
    assign pdst1 = has_dst[0] ? fl_head1 : fl_head0;  // First writer takes head0

    // Slot 1 reads or rewrites slot 0's destination
    assign dep1 = has_dst[0] && (group[1].src1 == group[0].dst);
    assign dep2 = has_dst[0] && (group[1].src2 == group[0].dst);
    assign waw  = has_dst[0] && (group[1].dst == group[0].dst);

    assign map_rd_areg[0] = group[0].src1;
    assign map_rd_areg[1] = group[0].src2;
    assign map_rd_areg[2] = group[1].src1;
    assign map_rd_areg[3] = group[1].src2;

    // Forwarded tags hit the set-port bypass and read busy
    assign bt_rd_tag[0] = map_rd_preg[0];
    assign bt_rd_tag[1] = map_rd_preg[1];
    assign bt_rd_tag[2] = dep1 ? pdst0 : map_rd_preg[2];
    assign bt_rd_tag[3] = dep2 ? pdst0 : map_rd_preg[3];

    assign fl_pop0 = go && (|has_dst);
    assign fl_pop1 = go && (&has_dst);

    assign map_wr0 = '{tgt: '{en: go && has_dst[0], tag: pdst0}, areg: group[0].dst};
    assign map_wr1 = '{tgt: '{en: go && has_dst[1], tag: pdst1}, areg: group[1].dst};
    assign bt_set0 = map_wr0.tgt;
    assign bt_set1 = map_wr1.tgt;

    ////////////////////////////////////////////////////////////////////
    // Result build
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        res_d[0] = '{valid: 1'b1, psrc1: bt_rd_tag[0], psrc2: bt_rd_tag[1],
                     src1_busy: bt_rd_busy[0], src2_busy: bt_rd_busy[1],
                     has_dst: has_dst[0], pdst: has_dst[0] ? pdst0 : '0,
                     old_pdst: has_dst[0] ? map_old0 : '0};
        res_d[1] = '{valid: 1'b1, psrc1: bt_rd_tag[2], psrc2: bt_rd_tag[3],
                     src1_busy: bt_rd_busy[2], src2_busy: bt_rd_busy[3],
                     has_dst: has_dst[1], pdst: has_dst[1] ? pdst1 : '0,
                     old_pdst: has_dst[1] ? (waw ? pdst0 : map_old1) : '0};
        // Empty slots report nothing
        for (int i = 0; i < `GROUP_N; i++) begin
            if (!group[i].valid) begin
                res_d[i] = '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Handshake FSM
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            DS_IDLE:   if (req) state_d = DS_RENAME;
            DS_RENAME: if (go) state_d = DS_ACK;     // Else stall on free list
            DS_ACK:    if (!req) state_d = DS_DROP;
            DS_DROP:   state_d = DS_IDLE;            // Ack falls here
            default:   state_d = DS_IDLE;
        endcase
        if (flush) begin
            state_d = DS_IDLE;  // Abandon handshake
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= DS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Held for the whole ack phase
    always_ff @(posedge clk) begin
        if (go) begin
            result_q <= res_d;
        end
    end

    assign ack    = (state_q == DS_ACK);
    assign result = result_q;

endmodule

// ==== rename/rename_map.sv ====
`include "rename_defines.svh"

module rename_map import rename_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    input  areg_t   rd_areg [2*`GROUP_N],  // Source lookups
    output preg_t   rd_preg [2*`GROUP_N],
    input  map_wr_t wr0,                   // Slot 0 destination
    input  map_wr_t wr1,                   // Slot 1 destination, wins a tie
    output preg_t   old0,                  // Mapping being replaced by wr0
    output preg_t   old1                   // Mapping being replaced by wr1
);

    ////////////////////////////////////////////////////////////////////
    // Map table
    ////////////////////////////////////////////////////////////////////

    preg_t map_q [`ARCH_REGS];  // Speculative arch to phys mapping

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= preg_t'(i);  // Identity
            end
        end else begin
            if (wr0.tgt.en) begin
                map_q[wr0.areg] <= wr0.tgt.tag;
            end
            // Younger write lands last
            if (wr1.tgt.en) begin
                map_q[wr1.areg] <= wr1.tgt.tag;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Lookups, all from pre-edge state
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < 2*`GROUP_N; i++) begin
            rd_preg[i] = map_q[rd_areg[i]];
        end
    end

    // Old mappings, valid whether or not the write is enabled
    assign old0 = map_q[wr0.areg];
    assign old1 = map_q[wr1.areg];

endmodule

// ==== rename/free_list.sv ====
`include "rename_defines.svh"

module free_list import rename_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               pop0,      // Take head0
    input  logic               pop1,      // Take head1 too, only with pop0
    output preg_t              head0,
    output preg_t              head1,
    output logic [`PREG_W-1:0] free_cnt,  // 0 to 32
    input  preg_port_t         push0,     // Commit release 0
    input  preg_port_t         push1      // Commit release 1
);

    localparam int DEPTH = `PHYS_REGS - `ARCH_REGS;  // Spare registers
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = `PREG_W;

    ////////////////////////////////////////////////////////////////////
    // Storage and pointers
    ////////////////////////////////////////////////////////////////////

    preg_t            fifo_q [DEPTH];
    logic [PTR_W-1:0] hd_q;           // Oldest free tag
    logic [PTR_W-1:0] tl_q;           // Next write slot
    logic [CNT_W-1:0] cnt_q;

    logic [PTR_W-1:0] hd_nx;          // Second read slot
    logic [PTR_W-1:0] wr_ptr1;        // Slot for push1
    logic [1:0]       n_pop;
    logic [1:0]       n_push;

    assign hd_nx   = hd_q + PTR_W'(1);  // Wraps at DEPTH
    assign wr_ptr1 = push0.en ? tl_q + PTR_W'(1) : tl_q;
    assign n_pop   = {1'b0, pop0} + {1'b0, pop1};
    assign n_push  = {1'b0, push0.en} + {1'b0, push1.en};

    // Heads are visible before the pop edge
    assign head0    = fifo_q[hd_q];
    assign head1    = fifo_q[hd_nx];
    assign free_cnt = cnt_q;

    ////////////////////////////////////////////////////////////////////
    // Update
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            // Refill with the upper half in ascending order
            for (int i = 0; i < DEPTH; i++) begin
                fifo_q[i] <= preg_t'(`ARCH_REGS + i);
            end
            hd_q  <= '0;
            tl_q  <= '0;              // Full, tail meets head
            cnt_q <= CNT_W'(DEPTH);
        end else begin
            if (push0.en) begin
                fifo_q[tl_q] <= push0.tag;
            end
            if (push1.en) begin
                fifo_q[wr_ptr1] <= push1.tag;
            end
            hd_q  <= hd_q + PTR_W'(n_pop);
            tl_q  <= tl_q + PTR_W'(n_push);
            cnt_q <= cnt_q + CNT_W'(n_push) - CNT_W'(n_pop);  // Net change
        end
    end

endmodule

// ==== rename/busy_table.sv ====
`include "rename_defines.svh"

module busy_table import rename_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,                  // Rollback clear
    input  preg_port_t set0,                   // Allocation, slot 0
    input  preg_port_t set1,                   // Allocation, slot 1
    input  preg_port_t clr0,                   // Integer writeback
    input  preg_port_t clr1,                   // Memory writeback
    input  preg_t      rd_tag  [2*`GROUP_N],   // Source tags of the group
    output logic       rd_busy [2*`GROUP_N]
);

    ////////////////////////////////////////////////////////////////////
    // Busy vector
    ////////////////////////////////////////////////////////////////////

    logic [`PHYS_REGS-1:0] busy_q;  // One bit per physical register

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy_q <= '0;  // Nothing in flight
        end else begin
            // Clears first
            if (clr0.en) begin
                busy_q[clr0.tag] <= 1'b0;
            end
            if (clr1.en) begin
                busy_q[clr1.tag] <= 1'b0;
            end
            // Sets last, so a set beats a clear of the same tag
            if (set0.en) begin
                busy_q[set0.tag] <= 1'b1;
            end
            if (set1.en) begin
                busy_q[set1.tag] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Read ports with same-cycle bypass
    ////////////////////////////////////////////////////////////////////

    // Order is set0, set1, clr0, clr1, then stored bit
    always_comb begin
        for (int i = 0; i < 2*`GROUP_N; i++) begin
            if (set0.en && (set0.tag == rd_tag[i])) begin
                rd_busy[i] = 1'b1;
            end else if (set1.en && (set1.tag == rd_tag[i])) begin
                rd_busy[i] = 1'b1;
            end else if (clr0.en && (clr0.tag == rd_tag[i])) begin
                rd_busy[i] = 1'b0;              // Result arriving now
            end else if (clr1.en && (clr1.tag == rd_tag[i])) begin
                rd_busy[i] = 1'b0;
            end else begin
                rd_busy[i] = busy_q[rd_tag[i]];
            end
        end
    end

endmodule

// ==== common/rename_pkg.sv ====
`include "rename_defines.svh"

package rename_pkg;

    // Register tags
    typedef logic [`AREG_W-1:0] areg_t;
    typedef logic [`PREG_W-1:0] preg_t;

    // Enable plus tag, shared by set, clear, push and pop ports
    typedef struct packed {
        logic  en;
        preg_t tag;
    } preg_port_t;

    // Map write port
    typedef struct packed {
        preg_port_t tgt;   // New physical tag
        areg_t      areg;  // Architectural register written
    } map_wr_t;

    ////////////////////////////////////////////////////////////////////
    // Dispatch request and result
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                   valid;
        core_ctrl_pkg::op_kind_e op;
        areg_t                  src1;
        areg_t                  src2;
        areg_t                  dst;
    } rn_instr_t;

    typedef rn_instr_t [`GROUP_N-1:0] rn_group_t;  // Slot 0 is older

    typedef struct packed {
        logic  valid;
        preg_t psrc1;
        preg_t psrc2;
        logic  src1_busy;
        logic  src2_busy;
        logic  has_dst;
        preg_t pdst;       // Newly allocated
        preg_t old_pdst;   // Freed at commit
    } rn_out_t;

    typedef rn_out_t [`GROUP_N-1:0] rn_result_t;

endpackage

// ==== common/core_ctrl_pkg.sv ====
package core_ctrl_pkg;

    // Operation kind of an incoming instruction
    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,  // Writes a destination
        OP_LOAD   = 2'd1,  // Writes a destination
        OP_STORE  = 2'd2,  // No destination
        OP_BRANCH = 2'd3   // No destination
    } op_kind_e;

    ////////////////////////////////////////////////////////////////////
    // Dispatch handshake FSM
    ////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        DS_IDLE   = 2'd0,  // Waiting for req
        DS_RENAME = 2'd1,  // Rename or stall on free list
        DS_ACK    = 2'd2,  // Ack high, result held
        DS_DROP   = 2'd3   // Ack low again
    } disp_state_e;

endpackage

// ==== common/rename_defines.svh ====
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

////////////////////////////////////////////////////////////////////////
// Register file sizing
////////////////////////////////////////////////////////////////////////

`define ARCH_REGS 32   // Architectural registers
`define PHYS_REGS 64   // Physical registers

// Tag widths
`define AREG_W 5
`define PREG_W 6

////////////////////////////////////////////////////////////////////////
// Dispatch
////////////////////////////////////////////////////////////////////////

`define GROUP_N 2      // Instructions per dispatch group

`endif
